//--- list.f
+incdir+hw
hw/int_block_pkg.sv
hw/dispatch_steer.sv
hw/exec_lane.sv
hw/writeback_bypass.sv
hw/int_exec_block.sv
bench/tb_int_exec_block.sv

//--- Makefile
# Verilator build and run of the integer execution block testbench

VERILATOR ?= verilator
TOP       ?= tb_int_exec_block
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hw/*.sv hw/*.svh bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test: $(SIM_BIN)
	$(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_int_exec_block.sv
`timescale 1ns/100ps
`include "int_block_consts.svh"

module tb_int_exec_block;
    import int_block_pkg::*;

    localparam int RAND_CYCLES = 400;
    // directed parts and reset stay well under 100 cycles
    localparam int unsigned MAX_CYCLES = 4 * (RAND_CYCLES + 100);
    localparam int PRD_NUM = 1 << `PRD_W;
    // registers 56 and up only ever arrive from the load ports
    localparam int PENDING_BASE = 56;
    localparam int unsigned NEVER = 32'h7fff_ffff;

    logic                   clk = 1'b0;
    logic                   rst;
    logic [`DISP_NUM-1:0]   disp_req;
    uop_t                   disp_uop [`DISP_NUM];
    logic [`DISP_NUM-1:0]   disp_vld;
    logic [1:0][`PRD_W-1:0] rf_idx [`LANE_NUM];
    logic [1:0][`XLEN-1:0]  rf_data [`LANE_NUM];
    logic [1:0]             rf_ready [`LANE_NUM];
    byp_t                   ext_wb [`EXT_WB_NUM];
    wb_t                    lane_wb [`LANE_NUM];
    logic [`LANE_NUM-1:0]   replay_vld;
    logic [`ROB_W-1:0]      replay_tag [`LANE_NUM];

    int unsigned cyc = 0;
    integer      seed;
    logic [`ROB_W-1:0] next_tag;

    // predicted register values as of the last accepted writer
    logic [`XLEN-1:0] val [PRD_NUM];
    // first operand-stage cycle in which a register can be resolved
    int unsigned      ready_at [PRD_NUM];

    // expectations per lane indexed by cycle modulo 8
    wb_t                    exp_wb [`LANE_NUM][8];
    int unsigned            wb_due [`LANE_NUM][8];
    logic [`ROB_W-1:0]      rep_tag [`LANE_NUM][8];
    int unsigned            rep_due [`LANE_NUM][8];
    logic [1:0][`PRD_W-1:0] idx_exp [`LANE_NUM][8];
    int unsigned            idx_due [`LANE_NUM][8];

    int_exec_block i_int_exec_block (
        .clk          (clk),
        .rst          (rst),
        .i_disp_req   (disp_req),
        .i_disp_uop   (disp_uop),
        .o_disp_vld   (disp_vld),
        .o_rf_idx     (rf_idx),
        .i_rf_data    (rf_data),
        .i_rf_ready   (rf_ready),
        .i_ext_wb     (ext_wb),
        .o_wb         (lane_wb),
        .o_replay_vld (replay_vld),
        .o_replay_tag (replay_tag)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    function automatic logic [`XLEN-1:0] init_value(input int r);
        return (32'h9e37_79b9 * (r + 1)) ^ {r[7:0], 24'h00a5c3};
    endfunction

    // branches report only the condition
    function automatic wb_t predict_wb(input uop_t u, input logic [31:0] a, input logic [31:0] b);
        wb_t w;
        w = '0;
        w.valid = 1'b1;
        w.rob_tag = u.rob_tag;
        w.rd_wen = u.rd_wen;
        w.prd_idx = u.prd_idx;
        case (u.op)
            op_add: w.result = a + b;
            op_sub: w.result = a - b;
            op_and: w.result = a & b;
            op_or:  w.result = a | b;
            op_xor: w.result = a ^ b;
            op_slt: w.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_beq: begin
                w.branch = 1'b1;
                w.taken = (a == b);
            end
            default: begin
                w.branch = 1'b1;
                w.taken = (a != b);
            end
        endcase
        return w;
    endfunction

    // never a register written by the current dispatch group
    function automatic int pick_source(input int grp);
        int r;
        r = $unsigned($random(seed)) % 48;
        if (r >= grp && r < grp + 4) begin
            r = r - 32;
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("ERR time %0t %s got %h expected %h", $time, name, got, want);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_slots();
        disp_req = '0;
        for (int s = 0; s < `DISP_NUM; s++) begin
            disp_uop[s] = '0;
        end
    endtask

    task automatic set_slot(input int s, input op_e op, input int src0, input int src1,
                            input int dst, input logic use_imm, input logic [31:0] imm);
        logic is_br;
        is_br = (op == op_beq || op == op_bne);
        disp_req[s] = 1'b1;
        disp_uop[s].rob_tag = next_tag;
        disp_uop[s].op = op;
        disp_uop[s].unit = is_br ? unit_bru : unit_alu;
        disp_uop[s].prs_idx[0] = src0[`PRD_W-1:0];
        disp_uop[s].prs_idx[1] = src1[`PRD_W-1:0];
        disp_uop[s].prd_idx = dst[`PRD_W-1:0];
        disp_uop[s].rd_wen = !is_br;
        disp_uop[s].use_imm = use_imm;
        disp_uop[s].imm = imm;
        next_tag = next_tag + 1'b1;
    endtask

    // steering model and the expected read, writeback or replay of each accepted slot
    task automatic issue();
        int                   g_cnt [2];
        int                   lane;
        int unsigned          t;
        logic                 blocked;
        logic                 ok;
        logic [`DISP_NUM-1:0] acc;
        logic [31:0]          a;
        logic [31:0]          b;
        uop_t                 u;
        g_cnt[0] = 0;
        g_cnt[1] = 0;
        blocked = 1'b0;
        acc = '0;
        t = cyc;
        #1;
        for (int s = 0; s < `DISP_NUM; s++) begin
            u = disp_uop[s];
            lane = -1;
            if (disp_req[s] && !blocked) begin
                if (u.unit == unit_alu && g_cnt[0] < 2) begin
                    lane = g_cnt[0];
                end else if (g_cnt[1] < 2) begin
                    lane = 2 + g_cnt[1];
                end else begin
                    blocked = 1'b1;
                end
            end
            if (lane >= 0) begin
                acc[s] = 1'b1;
                g_cnt[lane / 2] = g_cnt[lane / 2] + 1;
                idx_exp[lane][(t + 1) % 8] = u.prs_idx;
                idx_due[lane][(t + 1) % 8] = t + 1;
                a = val[u.prs_idx[0]];
                b = u.use_imm ? u.imm : val[u.prs_idx[1]];
                ok = (t + 2 >= ready_at[u.prs_idx[0]]) &&
                     (u.use_imm || t + 2 >= ready_at[u.prs_idx[1]]);
                if (ok) begin
                    exp_wb[lane][(t + 3) % 8] = predict_wb(u, a, b);
                    wb_due[lane][(t + 3) % 8] = t + 3;
                    if (u.rd_wen) begin
                        val[u.prd_idx] = exp_wb[lane][(t + 3) % 8].result;
                    end
                end else begin
                    rep_tag[lane][(t + 2) % 8] = u.rob_tag;
                    rep_due[lane][(t + 2) % 8] = t + 2;
                end
            end
        end
        assert (disp_vld === acc) else report_mismatch("o_disp_vld", 64'(disp_vld), 64'(acc));
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
            clear_slots();
            issue();
        end
    endtask

    // producer and consumers 1, 2 and 3 cycles apart
    task automatic run_chain();
        next_cycle();
        clear_slots();
        set_slot(0, op_add, 1, 0, 40, 1'b1, 32'd5);
        issue();
        next_cycle();
        clear_slots();
        set_slot(0, op_sub, 40, 2, 41, 1'b0, 32'd0);
        issue();
        idle(1);
        next_cycle();
        clear_slots();
        set_slot(0, op_xor, 41, 3, 42, 1'b0, 32'd0);
        issue();
        idle(2);
        next_cycle();
        clear_slots();
        set_slot(0, op_slt, 42, 41, 43, 1'b0, 32'd0);
        issue();
        idle(4);
    endtask

    task automatic run_load_cases();
        int unsigned c0;
        next_cycle();
        c0 = cyc;
        // r56 and r57 come in on load ports 0 and 1 three cycles from now
        ready_at[56] = c0 + 3;
        ready_at[57] = c0 + 3;
        val[57] = 32'h5a5a_0057;
        clear_slots();
        set_slot(0, op_add, 56, 0, 50, 1'b1, 32'd7);
        set_slot(1, op_add, 57, 1, 51, 1'b0, 32'd0);
        issue();
        next_cycle();
        clear_slots();
        set_slot(0, op_xor, 57, 0, 52, 1'b1, 32'h0000_0ff0);
        set_slot(1, op_and, 56, 57, 55, 1'b0, 32'd0);
        issue();
        next_cycle();
        clear_slots();
        set_slot(0, op_sub, 57, 2, 53, 1'b0, 32'd0);
        set_slot(1, op_add, 57, 56, 49, 1'b0, 32'd0);
        issue();
        next_cycle();
        ext_wb[0].valid = 1'b1;
        ext_wb[0].prd_idx = 6'd56;
        ext_wb[0].data = val[56];
        ext_wb[1].valid = 1'b1;
        ext_wb[1].prd_idx = 6'd57;
        ext_wb[1].data = val[57];
        clear_slots();
        issue();
        next_cycle();
        ext_wb[0].valid = 1'b0;
        ext_wb[1].valid = 1'b0;
        clear_slots();
        set_slot(0, op_or, 57, 3, 54, 1'b0, 32'd0);
        issue();
        idle(4);
    endtask

    task automatic run_random();
        int unsigned grp;
        int          sel;
        int          src0;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            next_cycle();
            clear_slots();
            grp = 32 + 4 * (cyc % 4);
            for (int s = 0; s < `DISP_NUM; s++) begin
                sel = $random(seed);
                src0 = pick_source(grp);
                if (sel[1:0] != 2'b00 && sel[3:2] == 2'b11) begin
                    // equal sources make beq taken
                    set_slot(s, sel[4] ? op_beq : op_bne, src0,
                             sel[5] ? src0 : pick_source(grp), grp + s, 1'b0, 32'd0);
                end else if (sel[1:0] != 2'b00) begin
                    set_slot(s, op_e'(sel[6:4] > 3'd5 ? 3'd0 : sel[6:4]), src0,
                             pick_source(grp), grp + s, sel[8], $random(seed));
                end
            end
            issue();
        end
    endtask

    // register file model with a registered read of the state before the edge
    initial begin
        logic [`XLEN-1:0]       regs [PRD_NUM];
        logic                   rdy [PRD_NUM];
        logic [1:0][`PRD_W-1:0] rd_idx [`LANE_NUM];
        wb_t                    wr_lane [`LANE_NUM];
        byp_t                   wr_ext [`EXT_WB_NUM];
        for (int r = 0; r < PRD_NUM; r++) begin
            regs[r] = init_value(r);
            rdy[r] = (r < PENDING_BASE);
        end
        for (int l = 0; l < `LANE_NUM; l++) begin
            rf_data[l] = '0;
            rf_ready[l] = '0;
        end
        forever begin
            @(negedge clk);
            rd_idx = rf_idx;
            wr_lane = lane_wb;
            wr_ext = ext_wb;
            @(posedge clk);
            #2;
            for (int l = 0; l < `LANE_NUM; l++) begin
                for (int k = 0; k < 2; k++) begin
                    rf_data[l][k] = regs[rd_idx[l][k]];
                    rf_ready[l][k] = rdy[rd_idx[l][k]];
                end
                if (wr_lane[l].valid && wr_lane[l].rd_wen) begin
                    regs[wr_lane[l].prd_idx] = wr_lane[l].result;
                    rdy[wr_lane[l].prd_idx] = 1'b1;
                end
            end
            for (int e = 0; e < `EXT_WB_NUM; e++) begin
                if (wr_ext[e].valid) begin
                    regs[wr_ext[e].prd_idx] = wr_ext[e].data;
                    rdy[wr_ext[e].prd_idx] = 1'b1;
                end
            end
        end
    end

    // outputs are compared mid-cycle
    initial begin
        int unsigned slot;
        logic        rep_exp;
        @(posedge clk);
        forever begin
            @(negedge clk);
            slot = cyc % 8;
            for (int l = 0; l < `LANE_NUM; l++) begin
                if (idx_due[l][slot] == cyc) begin
                    assert (rf_idx[l] === idx_exp[l][slot])
                        else report_mismatch($sformatf("o_rf_idx[%0d]", l),
                                             64'(rf_idx[l]), 64'(idx_exp[l][slot]));
                end
                if (wb_due[l][slot] == cyc) begin
                    assert (lane_wb[l] === exp_wb[l][slot])
                        else report_mismatch($sformatf("o_wb[%0d]", l),
                                             64'(lane_wb[l]), 64'(exp_wb[l][slot]));
                end else begin
                    assert (lane_wb[l].valid === 1'b0)
                        else report_mismatch($sformatf("o_wb[%0d].valid", l),
                                             64'(lane_wb[l].valid), 64'd0);
                end
                rep_exp = (rep_due[l][slot] == cyc);
                assert (replay_vld[l] === rep_exp)
                    else report_mismatch($sformatf("o_replay_vld[%0d]", l),
                                         64'(replay_vld[l]), 64'(rep_exp));
                if (rep_exp) begin
                    assert (replay_tag[l] === rep_tag[l][slot])
                        else report_mismatch($sformatf("o_replay_tag[%0d]", l),
                                             64'(replay_tag[l]), 64'(rep_tag[l][slot]));
                end
            end
        end
    end

    initial begin
        seed = 32'h1bb2;
        rst = 1'b1;
        next_tag = '0;
        clear_slots();
        for (int e = 0; e < `EXT_WB_NUM; e++) begin
            ext_wb[e] = '0;
        end
        for (int r = 0; r < PRD_NUM; r++) begin
            val[r] = init_value(r);
            ready_at[r] = (r < PENDING_BASE) ? 0 : NEVER;
        end
        for (int l = 0; l < `LANE_NUM; l++) begin
            for (int s = 0; s < 8; s++) begin
                exp_wb[l][s] = '0;
                wb_due[l][s] = NEVER;
                rep_tag[l][s] = '0;
                rep_due[l][s] = NEVER;
                idx_exp[l][s] = '0;
                idx_due[l][s] = NEVER;
            end
        end
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        // no writeback or replay may appear before the first dispatch
        idle(4);
        run_chain();
        run_load_cases();
        run_random();
        idle(8);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- hw/int_exec_block.sv
`timescale 1ns/100ps
`include "int_block_consts.svh"

module int_exec_block (
    input  logic                         clk,
    input  logic                         rst,
    // dispatch
    input  logic [`DISP_NUM-1:0]         i_disp_req,
    input  int_block_pkg::uop_t          i_disp_uop [`DISP_NUM],
    output logic [`DISP_NUM-1:0]         o_disp_vld,
    // register file read, one port pair per lane
    output logic [1:0][`PRD_W-1:0]       o_rf_idx [`LANE_NUM],
    input  logic [1:0][`XLEN-1:0]        i_rf_data [`LANE_NUM],
    input  logic [1:0]                   i_rf_ready [`LANE_NUM],
    // load writebacks
    input  int_block_pkg::byp_t          i_ext_wb [`EXT_WB_NUM],
    // results
    output int_block_pkg::wb_t           o_wb [`LANE_NUM],
    output logic [`LANE_NUM-1:0]         o_replay_vld,
    output logic [`ROB_W-1:0]            o_replay_tag [`LANE_NUM]
);
    import int_block_pkg::*;

    logic [`LANE_NUM-1:0] lane_vld;
    uop_t                 lane_uop [`LANE_NUM];
    byp_t                 byp [`BYP_NUM];

    dispatch_steer u_dispatch_steer (
        .i_disp_req  (i_disp_req),
        .i_disp_uop  (i_disp_uop),
        .o_disp_vld  (o_disp_vld),
        .o_lane_vld  (lane_vld),
        .o_lane_uop  (lane_uop)
    );

    // group 1 lanes also resolve branches
    for (genvar i = 0; i < `LANE_NUM; i++) begin : gen_lane
        exec_lane #(
            .BRANCH_UNIT ((i / `GROUP_LANES == 1) ? 1 : 0)
        ) u_exec_lane (
            .clk          (clk),
            .rst          (rst),
            .i_vld        (lane_vld[i]),
            .i_uop        (lane_uop[i]),
            .o_rf_idx     (o_rf_idx[i]),
            .i_rf_data    (i_rf_data[i]),
            .i_rf_ready   (i_rf_ready[i]),
            .i_byp        (byp),
            .o_wb         (o_wb[i]),
            .o_replay_vld (o_replay_vld[i]),
            .o_replay_tag (o_replay_tag[i])
        );
    end

    writeback_bypass u_writeback_bypass (
        .clk        (clk),
        .rst        (rst),
        .i_lane_wb  (o_wb),
        .i_ext_wb   (i_ext_wb),
        .o_byp      (byp)
    );

endmodule

//--- hw/writeback_bypass.sv
`timescale 1ns/100ps
`include "int_block_consts.svh"

module writeback_bypass (
    input  logic                  clk,
    input  logic                  rst,
    input  int_block_pkg::wb_t    i_lane_wb [`LANE_NUM],
    input  int_block_pkg::byp_t   i_ext_wb [`EXT_WB_NUM],
    output int_block_pkg::byp_t   o_byp [`BYP_NUM]
);
    import int_block_pkg::*;

    localparam int SRC_NUM = `LANE_NUM + `EXT_WB_NUM;

    // lanes first, then the load ports
    byp_t byp_now [SRC_NUM];
    byp_t byp_dly [SRC_NUM];

    always_comb begin
        for (int i = 0; i < `LANE_NUM; i++) begin
            // only writebacks that update a register are visible
            byp_now[i].valid   = i_lane_wb[i].valid && i_lane_wb[i].rd_wen;
            byp_now[i].prd_idx = i_lane_wb[i].prd_idx;
            byp_now[i].data    = i_lane_wb[i].result;
        end
        for (int e = 0; e < `EXT_WB_NUM; e++) begin
            byp_now[`LANE_NUM + e] = i_ext_wb[e];
        end
    end

    // delayed copy covers the cycle in which the regfile write lands
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < SRC_NUM; i++) begin
                byp_dly[i].valid <= 1'b0;
            end
        end else begin
            for (int i = 0; i < SRC_NUM; i++) begin
                byp_dly[i] <= byp_now[i];
            end
        end
    end

    // lane-now, ext-now, lane-delayed, ext-delayed
    always_comb begin
        for (int i = 0; i < SRC_NUM; i++) begin
            o_byp[i]           = byp_now[i];
            o_byp[SRC_NUM + i] = byp_dly[i];
        end
    end

endmodule

//--- hw/exec_lane.sv
`timescale 1ns/100ps
`include "int_block_consts.svh"

module exec_lane #(
    parameter int BRANCH_UNIT = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_vld,
    input  int_block_pkg::uop_t          i_uop,
    output logic [1:0][`PRD_W-1:0]       o_rf_idx,
    input  logic [1:0][`XLEN-1:0]        i_rf_data,
    input  logic [1:0]                   i_rf_ready,
    input  int_block_pkg::byp_t          i_byp [`BYP_NUM],
    output int_block_pkg::wb_t           o_wb,
    output logic                         o_replay_vld,
    output logic [`ROB_W-1:0]            o_replay_tag
);
    import int_block_pkg::*;

    // read stage
    logic rd_vld;
    uop_t rd_uop;

    // operand stage
    logic op_vld;
    uop_t op_uop;

    logic [1:0]              byp_hit;
    logic [1:0][`XLEN-1:0]   byp_data;
    logic [1:0]              src_ok;
    logic                    opnd_ok;
    logic [`XLEN-1:0]        src_a;
    logic [`XLEN-1:0]        src_b;

    wb_t wb_next;
    wb_t wb_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld <= 1'b0;
            op_vld <= 1'b0;
        end else begin
            rd_vld <= i_vld;
            rd_uop <= i_uop;
            op_vld <= rd_vld;
            op_uop <= rd_uop;
        end
    end

    // regfile answers these one cycle later
    assign o_rf_idx = rd_uop.prs_idx;

    // lowest matching bypass entry wins
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            byp_hit[k] = 1'b0;
            byp_data[k] = '0;
            for (int b = 0; b < `BYP_NUM; b++) begin
                if (!byp_hit[k] && i_byp[b].valid &&
                    i_byp[b].prd_idx == op_uop.prs_idx[k]) begin
                    byp_hit[k] = 1'b1;
                    byp_data[k] = i_byp[b].data;
                end
            end
        end
    end

    assign src_ok[0] = byp_hit[0] || i_rf_ready[0];
    assign src_ok[1] = op_uop.use_imm || byp_hit[1] || i_rf_ready[1];
    assign opnd_ok   = &src_ok;

    assign src_a = byp_hit[0] ? byp_data[0] : i_rf_data[0];
    assign src_b = op_uop.use_imm ? op_uop.imm :
                   (byp_hit[1] ? byp_data[1] : i_rf_data[1]);

    // unresolved operands are reported and the micro-op is dropped
    assign o_replay_vld = op_vld && !opnd_ok;
    assign o_replay_tag = op_uop.rob_tag;

    always_comb begin
        wb_next = '0;
        wb_next.valid   = op_vld && opnd_ok;
        wb_next.rob_tag = op_uop.rob_tag;
        wb_next.rd_wen  = op_uop.rd_wen;
        wb_next.prd_idx = op_uop.prd_idx;
        case (op_uop.op)
            op_add: wb_next.result = src_a + src_b;
            op_sub: wb_next.result = src_a - src_b;
            op_and: wb_next.result = src_a & src_b;
            op_or:  wb_next.result = src_a | src_b;
            op_xor: wb_next.result = src_a ^ src_b;
            op_slt: wb_next.result = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            op_beq: begin
                if (BRANCH_UNIT != 0) begin
                    wb_next.branch = 1'b1;
                    wb_next.taken  = (src_a == src_b);
                end
            end
            op_bne: begin
                if (BRANCH_UNIT != 0) begin
                    wb_next.branch = 1'b1;
                    wb_next.taken  = (src_a != src_b);
                end
            end
            default: wb_next.result = '0;
        endcase
    end

    // one cycle alu latency
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q.valid <= 1'b0;
        end else begin
            wb_q <= wb_next;
        end
    end

    assign o_wb = wb_q;

endmodule

//--- hw/dispatch_steer.sv
`timescale 1ns/100ps
`include "int_block_consts.svh"

module dispatch_steer (
    input  logic [`DISP_NUM-1:0]  i_disp_req,
    input  int_block_pkg::uop_t   i_disp_uop [`DISP_NUM],
    output logic [`DISP_NUM-1:0]  o_disp_vld,
    output logic [`LANE_NUM-1:0]  o_lane_vld,
    output int_block_pkg::uop_t   o_lane_uop [`LANE_NUM]
);
    import int_block_pkg::*;

    localparam int GROUP_NUM = `LANE_NUM / `GROUP_LANES;

    // per group, which dispatch slots it took this cycle
    logic [`DISP_NUM-1:0] grp_sel [GROUP_NUM];

    // in-order placement, the first slot that fits nowhere blocks the rest
    always_comb begin
        int unsigned g0_cnt;
        int unsigned g1_cnt;
        logic        blocked;
        logic        is_alu;
        g0_cnt = 0;
        g1_cnt = 0;
        blocked = 1'b0;
        grp_sel[0] = '0;
        grp_sel[1] = '0;
        for (int s = 0; s < `DISP_NUM; s++) begin
            is_alu = (i_disp_uop[s].unit == unit_alu);
            if (i_disp_req[s] && !blocked) begin
                if (is_alu && g0_cnt < `GROUP_LANES) begin
                    grp_sel[0][s] = 1'b1;
                    g0_cnt = g0_cnt + 1;
                end else if (g1_cnt < `GROUP_LANES) begin
                    // bru always lands here, alu only when group 0 is full
                    grp_sel[1][s] = 1'b1;
                    g1_cnt = g1_cnt + 1;
                end else begin
                    blocked = 1'b1;
                end
            end
        end
    end

    assign o_disp_vld = grp_sel[0] | grp_sel[1];

    // compaction, earliest accepted slot of a group gets its lower lane
    always_comb begin
        int unsigned fill;
        for (int l = 0; l < `LANE_NUM; l++) begin
            o_lane_vld[l] = 1'b0;
            o_lane_uop[l] = '0;
        end
        for (int g = 0; g < GROUP_NUM; g++) begin
            fill = 0;
            for (int s = 0; s < `DISP_NUM; s++) begin
                if (grp_sel[g][s] && fill < `GROUP_LANES) begin
                    o_lane_vld[g * `GROUP_LANES + fill] = 1'b1;
                    o_lane_uop[g * `GROUP_LANES + fill] = i_disp_uop[s];
                    fill = fill + 1;
                end
            end
        end
    end

endmodule

//--- hw/int_block_pkg.sv
`include "int_block_consts.svh"

package int_block_pkg;

    // unit class, decides which group may take the micro-op
    typedef enum logic {
        unit_alu = 1'b0,
        unit_bru = 1'b1
    } unit_e;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_slt = 3'd5,
        op_beq = 3'd6,
        op_bne = 3'd7
    } op_e;

    // dispatched micro-op, immediate travels with it
    typedef struct packed {
        logic [`ROB_W-1:0]           rob_tag;
        op_e                         op;
        unit_e                       unit;
        logic [1:0][`PRD_W-1:0]      prs_idx;
        logic [`PRD_W-1:0]           prd_idx;
        logic                        rd_wen;
        logic                        use_imm;
        logic [`XLEN-1:0]            imm;
    } uop_t;

    typedef struct packed {
        logic                        valid;
        logic [`ROB_W-1:0]           rob_tag;
        logic                        rd_wen;
        logic [`PRD_W-1:0]           prd_idx;
        logic [`XLEN-1:0]            result;
        logic                        branch;
        logic                        taken;
    } wb_t;

    // one entry of the bypass network
    typedef struct packed {
        logic                        valid;
        logic [`PRD_W-1:0]           prd_idx;
        logic [`XLEN-1:0]            data;
    } byp_t;

endpackage

//--- hw/int_block_consts.svh
`ifndef INT_BLOCK_CONSTS_SVH
`define INT_BLOCK_CONSTS_SVH

// datapath width
`define XLEN 32

// physical register index width
`define PRD_W 6

// reorder buffer tag width
`define ROB_W 7

// dispatch slots per cycle
`define DISP_NUM 4

// alu lanes, two groups of two
`define LANE_NUM 4
`define GROUP_LANES 2

// load writeback ports from outside the block
`define EXT_WB_NUM 2

// every source appears twice on the network, now and one cycle later
`define BYP_NUM (2 * (`LANE_NUM + `EXT_WB_NUM))

`endif
